// File: logic/board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ======================================================================
// Board sizing
// ======================================================================

// Push buttons on the board, key 3 doubles as reset
`define NUM_KEYS 4

// Consecutive stable samples before a key level is accepted
`define DEBOUNCE_CYCLES 16

// Cycles the system reset stays low once all sources are released
`define RESET_HOLD_CYCLES 8

// Seven-segment displays, four count bits each
`define NUM_DIGITS 6

`endif

// File: logic/key_pkg.sv
`include "board_config.svh"

package key_pkg;

  // One bit per key, active low, so a pressed key reads 0
  typedef logic [`NUM_KEYS-1:0] key_vec_t;

  // Stability counter, must be able to hold DEBOUNCE_CYCLES
  typedef logic [$clog2(`DEBOUNCE_CYCLES + 1)-1:0] dbc_count_t;

  // Key roles
  localparam int KEY_UP    = 0;
  localparam int KEY_DOWN  = 1;
  localparam int KEY_CLEAR = 2;
  localparam int KEY_RESET = 3;

endpackage : key_pkg

// File: logic/display_pkg.sv
`include "board_config.svh"

package display_pkg;

  // ======================================================================
  // Count and display types
  // ======================================================================

  // Press count, one hex digit per display, wraps modulo 2^24
  typedef logic [4*`NUM_DIGITS-1:0] press_count_t;

  // One hex digit
  typedef logic [3:0] hex_digit_t;

  // Segment pattern, active low
  // bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg7_t;

  // All segments dark
  localparam seg7_t SEG7_BLANK = 7'h7f;

endpackage : display_pkg

// File: logic/key_debouncer.sv
`timescale 1ns/1ns
`include "board_config.svh"

module key_debouncer
  import key_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic key,
  output logic level,
  output logic rise,
  output logic fall
);

  logic       sync_q1;
  logic       sync_q2;
  dbc_count_t stable_cnt;
  dbc_count_t stable_cnt_next;

  // Two-flop synchronizer, idles high like a released key
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
    end else begin
      sync_q1 <= key;
      sync_q2 <= sync_q1;
    end
  end

  assign stable_cnt_next = stable_cnt + 1'b1;

  // ======================================================================
  // Stability counter and accepted level
  // ======================================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level      <= 1'b1;
      rise       <= 1'b0;
      fall       <= 1'b0;
      stable_cnt <= '0;
    end else begin
      rise <= 1'b0;
      fall <= 1'b0;
      if (sync_q2 == level) begin
        // Bounced back, start over
        stable_cnt <= '0;
      end else if (stable_cnt_next == dbc_count_t'(`DEBOUNCE_CYCLES)) begin
        level      <= sync_q2;
        rise       <= sync_q2;
        fall       <= ~sync_q2;
        stable_cnt <= '0;
      end else begin
        stable_cnt <= stable_cnt_next;
      end
    end
  end

endmodule : key_debouncer

// File: logic/reset_sequencer.sv
`timescale 1ns/1ns
`include "board_config.svh"

module reset_sequencer (
  input  logic clk,
  input  logic arst_n,
  input  logic reset_key,
  input  logic pll_locked,
  output logic sys_rst_n
);

  typedef enum logic {
    HOLD,
    RUN
  } rst_state_t;

  localparam int HOLD_W = $clog2(`RESET_HOLD_CYCLES + 1);

  logic              src_rst_n;
  logic [1:0]        src_sync_q1;
  logic [1:0]        src_sync_q2;
  logic [HOLD_W-1:0] hold_cnt;
  rst_state_t        state;

  // Any low source asserts reset at once
  assign src_rst_n = arst_n & reset_key & pll_locked;

  // Release path only, key and lock flag resynchronized
  always_ff @(posedge clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      src_sync_q1 <= 2'b00;
      src_sync_q2 <= 2'b00;
    end else begin
      src_sync_q1 <= {reset_key, pll_locked};
      src_sync_q2 <= src_sync_q1;
    end
  end

  // Count out the hold time, then leave reset on a clock edge
  always_ff @(posedge clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      state    <= HOLD;
      hold_cnt <= '0;
    end else if (state == HOLD) begin
      if (hold_cnt != HOLD_W'(`RESET_HOLD_CYCLES)) begin
        hold_cnt <= hold_cnt + 1'b1;
      end else if (&src_sync_q2) begin
        state <= RUN;
      end
    end
  end

  assign sys_rst_n = (state == RUN);

endmodule : reset_sequencer

// File: logic/press_counter.sv
`timescale 1ns/1ns

module press_counter
  import key_pkg::*;
  import display_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  key_vec_t     key_fall,
  output press_count_t count
);

  logic         press_up;
  logic         press_down;
  logic         press_clear;
  press_count_t count_next;

  // Fall of an active-low key is a press
  assign press_up    = key_fall[KEY_UP];
  assign press_down  = key_fall[KEY_DOWN];
  assign press_clear = key_fall[KEY_CLEAR];

  // ======================================================================
  // Next count
  // ======================================================================

  always_comb begin
    count_next = count;
    if (press_clear) begin
      // Clear beats any other press
      count_next = '0;
    end else begin
      case ({press_up, press_down})
        2'b10:   count_next = count + 1'b1;
        2'b01:   count_next = count - 1'b1;
        // Up and down together cancel out
        default: count_next = count;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

endmodule : press_counter

// File: logic/hex_display.sv
`timescale 1ns/1ns
`include "board_config.svh"

module hex_display
  import display_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  press_count_t count,
  output seg7_t        hex0,
  output seg7_t        hex1,
  output seg7_t        hex2,
  output seg7_t        hex3,
  output seg7_t        hex4,
  output seg7_t        hex5
);

  seg7_t seg_next [`NUM_DIGITS];
  seg7_t seg_q    [`NUM_DIGITS];

  // Active-low hex font
  function automatic seg7_t hex_font(input hex_digit_t digit);
    case (digit)
      4'h0: hex_font = 7'h40;
      4'h1: hex_font = 7'h79;
      4'h2: hex_font = 7'h24;
      4'h3: hex_font = 7'h30;
      4'h4: hex_font = 7'h19;
      4'h5: hex_font = 7'h12;
      4'h6: hex_font = 7'h02;
      4'h7: hex_font = 7'h78;
      4'h8: hex_font = 7'h00;
      4'h9: hex_font = 7'h10;
      4'ha: hex_font = 7'h08;
      4'hb: hex_font = 7'h03;
      4'hc: hex_font = 7'h46;
      4'hd: hex_font = 7'h21;
      4'he: hex_font = 7'h06;
      default: hex_font = 7'h0e;
    endcase
  endfunction

  // Walk down from the top digit, light everything from the first nonzero
  always_comb begin : blank_sel
    logic       lit;
    hex_digit_t cur_digit;
    lit = 1'b0;
    for (int i = `NUM_DIGITS - 1; i >= 0; i--) begin
      cur_digit   = count[4*i +: 4];
      lit         = lit | (cur_digit != 4'h0) | (i == 0);
      seg_next[i] = lit ? hex_font(cur_digit) : SEG7_BLANK;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seg_q[0] <= hex_font(4'h0);
      for (int i = 1; i < `NUM_DIGITS; i++) begin
        seg_q[i] <= SEG7_BLANK;
      end
    end else begin
      seg_q <= seg_next;
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule : hex_display

// File: logic/board_ctrl_top.sv
`timescale 1ns/1ns
`include "board_config.svh"

module board_ctrl_top
  import key_pkg::*;
  import display_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  key_vec_t key,
  input  logic     pll_locked,
  output seg7_t    hex0,
  output seg7_t    hex1,
  output seg7_t    hex2,
  output seg7_t    hex3,
  output seg7_t    hex4,
  output seg7_t    hex5,
  output logic [4:0] led
);

  key_vec_t     key_dbc;
  key_vec_t     key_rise;
  key_vec_t     key_fall;
  logic         sys_rst_n;
  press_count_t count;

  // ======================================================================
  // Key inputs
  // ======================================================================

  for (genvar k = 0; k < `NUM_KEYS; k++) begin : g_dbc
    key_debouncer u_dbc (
      .clk    (clk),
      .arst_n (arst_n),
      .key    (key[k]),
      .level  (key_dbc[k]),
      .rise   (key_rise[k]),
      .fall   (key_fall[k])
    );
  end

  // ======================================================================
  // Reset, counter and display
  // ======================================================================

  reset_sequencer u_rst_seq (
    .clk        (clk),
    .arst_n     (arst_n),
    .reset_key  (key_dbc[KEY_RESET]),
    .pll_locked (pll_locked),
    .sys_rst_n  (sys_rst_n)
  );

  press_counter u_press_cnt (
    .clk      (clk),
    .arst_n   (sys_rst_n),
    .key_fall (key_fall),
    .count    (count)
  );

  hex_display u_hex_disp (
    .clk    (clk),
    .arst_n (sys_rst_n),
    .count  (count),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

  // Status LEDs for the reset path
  assign led[0] = key[KEY_RESET];
  assign led[1] = key_dbc[KEY_RESET];
  assign led[2] = pll_locked;
  assign led[3] = sys_rst_n;
  assign led[4] = key_dbc[KEY_CLEAR];

endmodule : board_ctrl_top

// File: bench/board_ctrl_props.sv
`timescale 1ns/1ns

module board_ctrl_props (
  input logic clk,
  input logic arst_n,
  input logic level,
  input logic rise,
  input logic fall,
  input logic pll_locked,
  input logic sys_rst_n
);

  // ======================================================================
  // Debouncer outputs
  // ======================================================================

  a_single_edge: assert property (@(posedge clk) disable iff (!arst_n) !(rise && fall))
    else $error("rise and fall pulses high in the same cycle");

  a_level_on_edge: assert property (@(posedge clk) disable iff (!arst_n)
    $changed(level) |-> (rise || fall))
    else $error("debounced level changed without an edge pulse");

  // Lock loss holds reset, two extra cycles for the release synchronizer
  a_lock_holds_reset: assert property (@(posedge clk) disable iff (!arst_n)
    (!pll_locked || !$past(pll_locked) || !$past(pll_locked, 2)) |-> !sys_rst_n)
    else $error("system reset released while the PLL was not locked");

endmodule : board_ctrl_props

bind key_debouncer board_ctrl_props u_dbc_props (
  .clk        (clk),
  .arst_n     (arst_n),
  .level      (level),
  .rise       (rise),
  .fall       (fall),
  .pll_locked (1'b1),
  .sys_rst_n  (1'b0)
);

bind board_ctrl_top board_ctrl_props u_top_props (
  .clk        (clk),
  .arst_n     (arst_n),
  .level      (1'b1),
  .rise       (1'b0),
  .fall       (1'b0),
  .pll_locked (pll_locked),
  .sys_rst_n  (sys_rst_n)
);

// File: bench/board_ctrl_tb.sv
`timescale 1ns/1ns
`include "board_config.svh"

module board_ctrl_tb
  import key_pkg::*;
  import display_pkg::*;
();

  localparam int DEB        = `DEBOUNCE_CYCLES;
  localparam int HOLD_LIMIT = `RESET_HOLD_CYCLES + 4;
  localparam int SEG_W      = 7 * `NUM_DIGITS;
  localparam seg7_t DARK    = 7'h7f;
  // Active-low font with bit 0 as segment a
  localparam seg7_t FONT [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

  logic         clk;
  logic         arst_n;
  logic         pll_locked;
  key_vec_t     key;
  seg7_t        hex0;
  seg7_t        hex1;
  seg7_t        hex2;
  seg7_t        hex3;
  seg7_t        hex4;
  seg7_t        hex5;
  logic [4:0]   led;
  press_count_t model_count;
  int           checks;
  int           errors;
  int           tests;
  int           checks_at_start;
  int           errors_at_start;

  board_ctrl_top dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .key        (key),
    .pll_locked (pll_locked),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5),
    .led        (led)
  );

  always #50 clk = ~clk;

  // ======================================================================
  // Reference model
  // ======================================================================

  function automatic press_count_t next_count(input press_count_t cnt, input key_vec_t mask);
    if (mask[KEY_CLEAR]) return '0;
    if (mask[KEY_UP] && !mask[KEY_DOWN]) return cnt + 1'b1;
    if (mask[KEY_DOWN] && !mask[KEY_UP]) return cnt - 1'b1;
    return cnt;
  endfunction

  // Digits above the highest nonzero one stay dark
  function automatic logic [SEG_W-1:0] expected_display(input press_count_t cnt);
    int top;
    logic [SEG_W-1:0] segs;
    top = 0;
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      if (cnt[4*i +: 4] != 4'h0) top = i;
    end
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      segs[7*i +: 7] = (i <= top) ? FONT[cnt[4*i +: 4]] : DARK;
    end
    return segs;
  endfunction

  task automatic check_display(input string what);
    logic [SEG_W-1:0] got;
    logic [SEG_W-1:0] exp;
    @(negedge clk);
    got = {hex5, hex4, hex3, hex2, hex1, hex0};
    exp = expected_display(model_count);
    checks++;
    assert (got == exp) else begin
      $display("MISMATCH at %0t ns: %s, display %h, expected %h for count %h",
               $time, what, got, exp, model_count);
      errors++;
    end
  endtask

  // Status LEDs as {clear level, system reset, lock, key 3 level, raw key 3}
  task automatic verify_leds(input logic [4:0] exp, input string what);
    @(negedge clk);
    checks++;
    assert (led === exp) else begin
      $display("MISMATCH at %0t ns: %s, leds %b, expected %b", $time, what, led, exp);
      errors++;
    end
  endtask

  task automatic wait_led(input int idx, input logic value, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (led[idx] !== value && n < limit) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (led[idx] !== value) begin
      $display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, limit);
      errors++;
    end
  endtask

  // ======================================================================
  // Key stimulus
  // ======================================================================

  // Same random bit on every pressed key so combined presses land together
  task automatic bounce(input key_vec_t mask);
    int len;
    len = 1 + $urandom % (DEB - 4);
    repeat (len) begin
      @(posedge clk);
      if ($urandom % 2 == 0) key <= ~mask;
      else key <= '1;
    end
  endtask

  task automatic hold_keys(input key_vec_t value);
    @(posedge clk);
    key <= value;
    repeat (3 * DEB - 1) @(posedge clk);
  endtask

  task automatic press_keys(input key_vec_t mask, input string what);
    bounce(mask);
    hold_keys(~mask);
    verify_leds({~mask[KEY_CLEAR], 4'b1111}, what);
    bounce(mask);
    hold_keys('1);
    model_count = next_count(model_count, mask);
    check_display(what);
    verify_leds(5'b11111, what);
  endtask

  // Low pulse too short to be accepted
  task automatic glitch_key(input int k);
    int len;
    len = 1 + $urandom % (DEB - 3);
    @(posedge clk);
    key <= ~(key_vec_t'(1) << k);
    repeat (len) @(posedge clk);
    key <= '1;
    repeat (2 * DEB) @(posedge clk);
    check_display("after glitch");
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s: %0d of %0d checks failed", tests, name,
             errors - errors_at_start, checks - checks_at_start);
    errors_at_start = errors;
    checks_at_start = checks;
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    pll_locked = 1'b0;
    key = '1;
    model_count = '0;
    checks = 0;
    errors = 0;
    tests = 0;
    checks_at_start = 0;
    errors_at_start = 0;
    void'($urandom(32'h5d33));
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    pll_locked <= 1'b1;
    wait_led(3, 1'b1, HOLD_LIMIT, "first system reset release");
    check_display("after power-on");
    verify_leds(5'b11111, "after power-on");
    finish_test("power-on reset");

    repeat (24) press_keys(($urandom % 2 == 0) ? 4'b0001 : 4'b0010, "random up/down");
    finish_test("random up and down presses");

    repeat (10) glitch_key($urandom % 3);
    finish_test("short glitches");

    repeat (3) press_keys(4'b0001, "count up");
    press_keys(4'b0100, "clear");
    repeat (2) press_keys(4'b0001, "count up");
    press_keys(4'b0101, "clear with up");
    finish_test("clear key");

    repeat (2) press_keys(4'b0001, "count up");
    bounce(4'b1000);
    @(posedge clk);
    key <= 4'b0111;
    wait_led(3, 1'b0, DEB + 4, "system reset from key 3");
    model_count = '0;
    check_display("reset by key 3");
    verify_leds(5'b10100, "reset by key 3");
    bounce(4'b1000);
    @(posedge clk);
    key <= '1;
    wait_led(1, 1'b1, DEB + 4, "key 3 release");
    wait_led(3, 1'b1, HOLD_LIMIT, "system reset release after key 3");
    check_display("after key 3 release");
    press_keys(4'b0001, "count up");
    @(posedge clk);
    pll_locked <= 1'b0;
    wait_led(3, 1'b0, 2, "system reset on lock loss");
    model_count = '0;
    check_display("reset by lock loss");
    verify_leds(5'b10011, "reset by lock loss");
    repeat (4) @(posedge clk);
    pll_locked <= 1'b1;
    wait_led(3, 1'b1, HOLD_LIMIT, "system reset release after relock");
    check_display("after relock");
    verify_leds(5'b11111, "after relock");
    finish_test("reset key and lock loss");

    press_keys(4'b0010, "down from zero");
    press_keys(4'b0001, "up from all ones");
    finish_test("wrap around");

    $display("%0d tests, %0d checks, %0d failed", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : board_ctrl_tb

// File: verilog.f
+incdir+logic
logic/key_pkg.sv
logic/display_pkg.sv
logic/key_debouncer.sv
logic/reset_sequencer.sv
logic/press_counter.sv
logic/hex_display.sv
logic/board_ctrl_top.sv
bench/board_ctrl_props.sv
bench/board_ctrl_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := board_ctrl_tb
FILELIST  := verilog.f
OBJDIR    := obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Passes only if the pass line shows up in the simulator output
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x 'No errors' > /dev/null

clean:
	rm -rf $(OBJDIR)
